//--- hw/host_tile.sv
/*
 * Host tile at ring stop 0
 * Turns external strobes into request flits, returns responses and decode errors
 */
module host_tile (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // External side
  input  logic               req_valid_i,
  input  logic               req_write_i,
  input  mem_map_pkg::addr_t req_addr_i,
  input  mem_map_pkg::data_t req_wdata_i,
  input  mem_map_pkg::tag_t  req_tag_i,
  output logic               rsp_valid_o,
  output mem_map_pkg::data_t rsp_rdata_o,
  output mem_map_pkg::tag_t  rsp_tag_o,
  output logic               rsp_err_o,
  // Ring side
  output logic               inj_valid_o,
  output noc_pkg::node_id_t  inj_dst_o,
  output noc_pkg::req_flit_t inj_flit_o,
  input  logic               ej_valid_i,
  input  noc_pkg::rsp_flit_t ej_flit_i
);
  import noc_pkg::*;
  import mem_map_pkg::*;

  node_id_t target;
  logic     mapped, err_new;
  logic     err_valid_q;
  tag_t     err_tag_q;

  // Address decode
  assign target  = region_to_node(req_addr_i);
  assign mapped  = (target != HostNode);
  assign err_new = req_valid_i && !mapped;

  // Mapped strobes go straight into the request router
  assign inj_valid_o = req_valid_i && mapped;
  assign inj_dst_o   = target;
  assign inj_flit_o  = '{src:   HostNode,
                         write: req_write_i,
                         idx:   req_addr_i[WordIdxWidth-1:0],
                         wdata: req_wdata_i,
                         tag:   req_tag_i};

  //////////////////////////////////////////////////////////////////////
  // Error slot and response register
  //////////////////////////////////////////////////////////////////////

  // Network responses win, a pending error waits one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      rsp_valid_o <= ej_valid_i || err_valid_q || err_new;
      if (ej_valid_i) err_valid_q <= err_valid_q || err_new;
      else            err_valid_q <= err_valid_q && err_new;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_new && (ej_valid_i || err_valid_q)) err_tag_q <= req_tag_i;
    if (ej_valid_i) begin
      rsp_rdata_o <= ej_flit_i.rdata;
      rsp_tag_o   <= ej_flit_i.tag;
      rsp_err_o   <= 1'b0;
    end else if (err_valid_q) begin
      rsp_rdata_o <= '0;
      rsp_tag_o   <= err_tag_q;
      rsp_err_o   <= 1'b1;
    end else if (err_new) begin
      rsp_rdata_o <= '0;
      rsp_tag_o   <= req_tag_i;
      rsp_err_o   <= 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   (err_valid_q && ej_valid_i) |-> !err_new)
    else $error("host_tile: error slot overwritten while full");

endmodule

//--- hw/mem_map_pkg.sv
/*
 * Memory map of the ring network
 * Word address layout, data and tag widths, opcodes, scratchpad size
 */
package mem_map_pkg;

  localparam int unsigned DataWidth    = 32;
  localparam int unsigned TagWidth     = 4;
  localparam int unsigned AddrWidth    = 10;
  localparam int unsigned SpmWords     = 64;
  localparam int unsigned WordIdxWidth = $clog2(SpmWords);

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [TagWidth-1:0]     tag_t;
  typedef logic [WordIdxWidth-1:0] word_idx_t;

  // Write flag encoding in request flits
  localparam logic OpRead  = 1'b0;
  localparam logic OpWrite = 1'b1;

  // Top two address bits select the region
  localparam logic [1:0] UnmappedRegion = 2'd3;

  // Region 0..2 goes to node 1..3
  // Zero marks the unmapped region, node 0 is never a target
  function automatic logic [1:0] region_to_node(addr_t addr);
    logic [1:0] region;
    region = addr[AddrWidth-1 -: 2];
    if (region == UnmappedRegion) return 2'd0;
    return region + 2'd1;
  endfunction

endpackage

//--- hw/mem_tile.sv
/*
 * Scratchpad memory tile
 * Serves ejected request flits and answers the source node
 */
module mem_tile #(
  parameter noc_pkg::node_id_t NodeId = 2'd1
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ej_valid_i,
  input  noc_pkg::req_flit_t ej_flit_i,
  output logic               inj_valid_o,
  output noc_pkg::node_id_t  inj_dst_o,
  output noc_pkg::rsp_flit_t inj_flit_o
);
  import noc_pkg::*;
  import mem_map_pkg::*;

  data_t spm_q [SpmWords];

  logic is_write;

  assign is_write = ej_valid_i && (ej_flit_i.write == OpWrite);

  //////////////////////////////////////////////////////////////////////
  // Scratchpad
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (is_write) spm_q[ej_flit_i.idx] <= ej_flit_i.wdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  // Served one cycle after ejection, goes straight to the response router
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inj_valid_o <= 1'b0;
    end else begin
      inj_valid_o <= ej_valid_i;
    end
  end

  // Writes are acknowledged with zero data
  always_ff @(posedge clk_i) begin
    if (ej_valid_i) begin
      inj_dst_o      <= ej_flit_i.src;
      inj_flit_o.tag <= ej_flit_i.tag;
      if (ej_flit_i.write == OpRead) inj_flit_o.rdata <= spm_q[ej_flit_i.idx];
      else                           inj_flit_o.rdata <= '0;
    end
  end

  // Only the host issues requests, a memory tile never hears from itself
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   ej_valid_i |-> ej_flit_i.src != NodeId)
    else $error("mem_tile %0d: request from own node", NodeId);

endmodule

//--- hw/noc_pkg.sv
/*
 * Ring network definitions
 * Node numbering, injection queue sizing and the two flit types
 */
package noc_pkg;

  localparam int unsigned NumNodes = 4;

  typedef logic [1:0] node_id_t;

  // Host sits at ring stop 0, memory tiles follow
  localparam node_id_t HostNode = 2'd0;

  // Local injection queue per router
  localparam int unsigned InjDepth    = 4;
  localparam int unsigned InjPtrWidth = $clog2(InjDepth);

  // Upstream neighbour of a stop, links run 0 -> 1 -> 2 -> 3 -> 0
  function automatic int unsigned prev_node(int unsigned n);
    return (n + NumNodes - 1) % NumNodes;
  endfunction

  typedef struct packed {
    node_id_t               src;
    logic                   write;
    mem_map_pkg::word_idx_t idx;
    mem_map_pkg::data_t     wdata;
    mem_map_pkg::tag_t      tag;
  } req_flit_t;

  typedef struct packed {
    mem_map_pkg::data_t rdata;
    mem_map_pkg::tag_t  tag;
  } rsp_flit_t;

endpackage

//--- hw/ring_noc_top.sv
/*
 * Ring network top level
 * Request and response rings of four stops, one host tile, three memory tiles
 */
module ring_noc_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  logic               req_write_i,
  input  mem_map_pkg::addr_t req_addr_i,
  input  mem_map_pkg::data_t req_wdata_i,
  input  mem_map_pkg::tag_t  req_tag_i,
  output logic               rsp_valid_o,
  output mem_map_pkg::data_t rsp_rdata_o,
  output mem_map_pkg::tag_t  rsp_tag_o,
  output logic               rsp_err_o
);
  import noc_pkg::*;

  // Ring links, index n is the output of stop n
  logic      req_link_valid [NumNodes];
  node_id_t  req_link_dst   [NumNodes];
  req_flit_t req_link_flit  [NumNodes];
  logic      rsp_link_valid [NumNodes];
  node_id_t  rsp_link_dst   [NumNodes];
  rsp_flit_t rsp_link_flit  [NumNodes];

  // Local ports of each stop
  logic      req_inj_valid [NumNodes];
  node_id_t  req_inj_dst   [NumNodes];
  req_flit_t req_inj_flit  [NumNodes];
  logic      req_ej_valid  [NumNodes];
  req_flit_t req_ej_flit   [NumNodes];
  logic      rsp_inj_valid [NumNodes];
  node_id_t  rsp_inj_dst   [NumNodes];
  rsp_flit_t rsp_inj_flit  [NumNodes];
  logic      rsp_ej_valid  [NumNodes];
  rsp_flit_t rsp_ej_flit   [NumNodes];

  //////////////////////////////////////////////////////////////////////
  // Ring stops
  //////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < NumNodes; n++) begin : gen_stop
    ring_router #(
      .NodeId (node_id_t'(n)),
      .flit_t (req_flit_t)
    ) u_req_router (
      .clk_i,
      .rst_n_i,
      .ring_valid_i (req_link_valid[prev_node(n)]),
      .ring_dst_i   (req_link_dst[prev_node(n)]),
      .ring_flit_i  (req_link_flit[prev_node(n)]),
      .ring_valid_o (req_link_valid[n]),
      .ring_dst_o   (req_link_dst[n]),
      .ring_flit_o  (req_link_flit[n]),
      .inj_valid_i  (req_inj_valid[n]),
      .inj_dst_i    (req_inj_dst[n]),
      .inj_flit_i   (req_inj_flit[n]),
      .ej_valid_o   (req_ej_valid[n]),
      .ej_flit_o    (req_ej_flit[n])
    );

    ring_router #(
      .NodeId (node_id_t'(n)),
      .flit_t (rsp_flit_t)
    ) u_rsp_router (
      .clk_i,
      .rst_n_i,
      .ring_valid_i (rsp_link_valid[prev_node(n)]),
      .ring_dst_i   (rsp_link_dst[prev_node(n)]),
      .ring_flit_i  (rsp_link_flit[prev_node(n)]),
      .ring_valid_o (rsp_link_valid[n]),
      .ring_dst_o   (rsp_link_dst[n]),
      .ring_flit_o  (rsp_link_flit[n]),
      .inj_valid_i  (rsp_inj_valid[n]),
      .inj_dst_i    (rsp_inj_dst[n]),
      .inj_flit_i   (rsp_inj_flit[n]),
      .ej_valid_o   (rsp_ej_valid[n]),
      .ej_flit_o    (rsp_ej_flit[n])
    );

    // Host never answers, memory tiles never request
    if (n == HostNode) begin : gen_host_ties
      assign rsp_inj_valid[n] = 1'b0;
      assign rsp_inj_dst[n]   = '0;
      assign rsp_inj_flit[n]  = '0;
    end else begin : gen_mem_ties
      assign req_inj_valid[n] = 1'b0;
      assign req_inj_dst[n]   = '0;
      assign req_inj_flit[n]  = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tiles
  //////////////////////////////////////////////////////////////////////

  host_tile u_host_tile (
    .clk_i,
    .rst_n_i,
    .req_valid_i,
    .req_write_i,
    .req_addr_i,
    .req_wdata_i,
    .req_tag_i,
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_tag_o,
    .rsp_err_o,
    .inj_valid_o (req_inj_valid[HostNode]),
    .inj_dst_o   (req_inj_dst[HostNode]),
    .inj_flit_o  (req_inj_flit[HostNode]),
    .ej_valid_i  (rsp_ej_valid[HostNode]),
    .ej_flit_i   (rsp_ej_flit[HostNode])
  );

  for (genvar m = 1; m < NumNodes; m++) begin : gen_mem_tile
    mem_tile #(
      .NodeId (node_id_t'(m))
    ) u_mem_tile (
      .clk_i,
      .rst_n_i,
      .ej_valid_i  (req_ej_valid[m]),
      .ej_flit_i   (req_ej_flit[m]),
      .inj_valid_o (rsp_inj_valid[m]),
      .inj_dst_o   (rsp_inj_dst[m]),
      .inj_flit_o  (rsp_inj_flit[m])
    );
  end

endmodule

//--- hw/ring_router.sv
/*
 * Ring stop for a unidirectional ring
 * Forwards transit flits, ejects local ones and queues injections
 */
module ring_router #(
  parameter noc_pkg::node_id_t NodeId = 2'd0,
  parameter type               flit_t = logic
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Ring side
  input  logic              ring_valid_i,
  input  noc_pkg::node_id_t ring_dst_i,
  input  flit_t             ring_flit_i,
  output logic              ring_valid_o,
  output noc_pkg::node_id_t ring_dst_o,
  output flit_t             ring_flit_o,
  // Local side
  input  logic              inj_valid_i,
  input  noc_pkg::node_id_t inj_dst_i,
  input  flit_t             inj_flit_i,
  output logic              ej_valid_o,
  output flit_t             ej_flit_o
);
  import noc_pkg::*;

  logic [InjPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [InjPtrWidth:0]   count_q;
  node_id_t               dst_mem [InjDepth];
  flit_t                  flit_mem [InjDepth];

  logic transit, local_hit;
  logic q_empty, q_full;
  logic send_head, bypass, push;

  assign transit   = ring_valid_i && (ring_dst_i != NodeId);
  assign local_hit = ring_valid_i && (ring_dst_i == NodeId);
  assign q_empty   = (count_q == '0);
  assign q_full    = (count_q == InjDepth);

  // Transit traffic owns the output, local flits take free slots
  assign send_head = !transit && !q_empty;
  assign bypass    = !transit && q_empty && inj_valid_i;
  assign push      = inj_valid_i && !bypass;

  //////////////////////////////////////////////////////////////////////
  // Injection queue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      dst_mem[wr_ptr_q]  <= inj_dst_i;
      flit_mem[wr_ptr_q] <= inj_flit_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      ring_valid_o <= 1'b0;
      ej_valid_o   <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (send_head) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !send_head) begin
        count_q <= count_q + 1'b1;
      end else if (send_head && !push) begin
        count_q <= count_q - 1'b1;
      end
      ring_valid_o <= transit || send_head || bypass;
      ej_valid_o   <= local_hit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (transit) begin
      ring_dst_o  <= ring_dst_i;
      ring_flit_o <= ring_flit_i;
    end else if (send_head) begin
      ring_dst_o  <= dst_mem[rd_ptr_q];
      ring_flit_o <= flit_mem[rd_ptr_q];
    end else if (bypass) begin
      ring_dst_o  <= inj_dst_i;
      ring_flit_o <= inj_flit_i;
    end
    if (local_hit) ej_flit_o <= ring_flit_i;
  end

  // Host spacing must keep the queue within its depth
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(push && q_full))
    else $error("ring_router %0d: injection queue pushed while full", NodeId);

  // A tile never sends a flit to itself through the ring
  assert property (@(posedge clk_i) disable iff (!rst_n_i) inj_valid_i |-> inj_dst_i != NodeId)
    else $error("ring_router %0d: injection addressed to own node", NodeId);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ring network testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_ring_noc_top
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module "$TOP" -o "V$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" "$SIM_LOG"; then
  exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

//--- testbench/tb_ring_noc_top.sv
/*
 * Testbench for the ring network top level
 * Seeded random traffic against a scratchpad model and a tag scoreboard
 */
module tb_ring_noc_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumTags    = 16;
  localparam int unsigned RandomReqs = 300;
  localparam int unsigned TotalReqs  = 6 + RandomReqs + 7;
  localparam int unsigned CycleLimit = TotalReqs * 40 + 200;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        req_valid_i;
  logic        req_write_i;
  logic [9:0]  req_addr_i;
  logic [31:0] req_wdata_i;
  logic [3:0]  req_tag_i;
  logic        rsp_valid_o;
  logic [31:0] rsp_rdata_o;
  logic [3:0]  rsp_tag_o;
  logic        rsp_err_o;

  // Scratchpad model per tile with tile 0 left unused
  logic [31:0] mem_model [4][64];
  logic        written   [4][64];
  // Outstanding tags and what each should return
  logic        busy    [NumTags];
  logic [31:0] exp_data[NumTags];
  logic        exp_err [NumTags];

  int unsigned errors = 0;
  int unsigned issued = 0;
  int unsigned answered = 0;
  int unsigned responses = 0;
  int unsigned cycles = 0;
  int unsigned test_start;
  logic [5:0]  base_idx [4];

  ring_noc_top u_ring_noc_top (.*);

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk_i);
    #2;
  endtask

  function automatic int free_tag(int unsigned start);
    for (int i = 0; i < NumTags; i++) begin
      if (!busy[(start + i) % NumTags]) return (start + i) % NumTags;
    end
    return -1;
  endfunction

  // One strobe, then at least one idle cycle
  task automatic issue(input logic write, input logic [9:0] addr, input logic [31:0] wdata);
    int tag;
    int unsigned region;
    int unsigned node;
    tag = free_tag($urandom_range(NumTags - 1));
    while (tag < 0) begin
      wait_cycle();
      tag = free_tag($urandom_range(NumTags - 1));
    end
    region = addr[9:8];
    node   = region + 1;
    exp_err[tag]  = (region == 3);
    exp_data[tag] = 32'h0;
    if (region != 3) begin
      if (write) begin
        mem_model[node][addr[5:0]] = wdata;
        written[node][addr[5:0]]   = 1'b1;
      end else begin
        exp_data[tag] = mem_model[node][addr[5:0]];
      end
    end
    busy[tag]   = 1'b1;
    issued++;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_tag_i   = 4'(tag);
    wait_cycle();
    req_valid_i = 1'b0;
    wait_cycle();
    repeat ($urandom_range(2)) wait_cycle();
  endtask

  task automatic drain();
    while (answered != issued) wait_cycle();
  endtask

  task automatic report(input int unsigned num, input string name);
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == test_start) ? "ok" : "failed", errors - test_start);
    test_start = errors;
  endtask

  // Responses are checked on the falling edge
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && rsp_valid_o === 1'b1) begin
      responses++;
      if (!busy[rsp_tag_o]) begin
        $display("error at %0t ns: response with tag %0d that is not outstanding",
                 $time, rsp_tag_o);
        errors++;
      end else begin
        check_value("rsp_err_o", 32'(exp_err[rsp_tag_o]), 32'(rsp_err_o));
        if (!exp_err[rsp_tag_o]) check_value("rsp_rdata_o", exp_data[rsp_tag_o], rsp_rdata_o);
        busy[rsp_tag_o] = 1'b0;
        answered++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("timeout: run still busy after %0d cycles", CycleLimit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic        wr;
    logic [1:0]  region;
    logic [5:0]  idx;
    void'($urandom(32));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_tag_i   = '0;
    test_start  = 0;
    for (int t = 0; t < 4; t++) begin
      for (int w = 0; w < 64; w++) written[t][w] = 1'b0;
    end
    for (int i = 0; i < NumTags; i++) busy[i] = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    ////////////////////////////////////////////////////////////////////
    // Idle after reset
    ////////////////////////////////////////////////////////////////////
    repeat (10) begin
      check_value("rsp_valid_o", 32'h0, 32'(rsp_valid_o));
      wait_cycle();
    end
    report(1, "idle after reset");

    // Write then read back on each memory tile
    for (int t = 0; t < 3; t++) begin
      base_idx[t] = 6'($urandom_range(63));
      issue(1'b1, {2'(t), 2'b00, base_idx[t]}, $urandom);
      issue(1'b0, {2'(t), 2'b00, base_idx[t]}, 32'h0);
    end
    drain();
    report(2, "write and read back");

    ////////////////////////////////////////////////////////////////////
    // Random traffic with responses possibly out of order
    ////////////////////////////////////////////////////////////////////
    for (int i = 0; i < RandomReqs; i++) begin
      wr     = 1'($urandom_range(1));
      region = 2'($urandom_range(2));
      idx    = 6'($urandom_range(63));
      // Scratchpad is not reset so an unwritten word is never read
      if (!written[region + 1][idx]) wr = 1'b1;
      issue(wr, {region, 2'b00, idx}, $urandom);
    end
    drain();
    report(3, "random traffic");

    // Unmapped region must not touch any scratchpad
    for (int t = 0; t < 3; t++) issue(1'b1, {2'b11, 2'b00, base_idx[t]}, $urandom);
    issue(1'b0, {2'b11, 2'b00, base_idx[0]}, 32'h0);
    for (int t = 0; t < 3; t++) issue(1'b0, {2'(t), 2'b00, base_idx[t]}, 32'h0);
    drain();
    report(4, "unmapped region");

    // A late or repeated response would land in this window
    repeat (40) wait_cycle();
    check_value("response count", issued, responses);
    report(5, "every tag answered once");

    $display("requests %0d, responses %0d, errors %0d", issued, responses, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/mem_map_pkg.sv
hw/noc_pkg.sv
hw/ring_router.sv
hw/host_tile.sv
hw/mem_tile.sv
hw/ring_noc_top.sv
testbench/tb_ring_noc_top.sv
